/* rtl/cache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_arrays #(
    parameter int sets_p        = 16,
    parameter int block_words_p = 4,
    localparam int offset_w     = $clog2(block_words_p) + 2,
    localparam int index_w      = $clog2(sets_p),
    localparam int tag_w        = 32 - offset_w - index_w,
    localparam int block_bits   = block_words_p * 32
) (
    input  wire logic                        clk_i,
    input  wire logic                        nreset_i,
    input  wire logic                        rd_en_i,
    input  wire logic [index_w-1:0]          set_index_i,
    input  wire logic                        wr_en_i,
    input  wire logic                        wr_way_i,
    input  wire logic [tag_w-1:0]            wr_tag_i,
    input  wire wb_cache_pkg::block_state_e  wr_state_i,
    input  wire logic [block_bits-1:0]       wr_data_i,
    output logic [1:0][tag_w-1:0]            way_tag_o,
    output wb_cache_pkg::block_state_e [1:0] way_state_o,
    output logic [1:0][block_bits-1:0]       way_data_o,
    output logic                             init_done_o
);

    logic [index_w:0] sweep_cnt_r;

    // one set per cycle is invalidated after reset
    assign init_done_o = sweep_cnt_r == (index_w+1)'(sets_p);

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            sweep_cnt_r <= '0;
        end else if (!init_done_o) begin
            sweep_cnt_r <= sweep_cnt_r + 1'b1;
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [tag_w-1:0]           tag_mem [sets_p];
        wb_cache_pkg::block_state_e state_mem [sets_p];
        logic [block_bits-1:0]      data_mem [sets_p];
        logic [tag_w-1:0]           tag_q;
        wb_cache_pkg::block_state_e state_q;
        logic [block_bits-1:0]      data_q;
        logic                       way_we;

        assign way_we = wr_en_i && (wr_way_i == 1'(w));

        always_ff @(posedge clk_i) begin
            if (!init_done_o) begin
                state_mem[sweep_cnt_r[index_w-1:0]] <= wb_cache_pkg::state_invalid;
            end else if (way_we) begin
                tag_mem[set_index_i]   <= wr_tag_i;
                state_mem[set_index_i] <= wr_state_i;
                data_mem[set_index_i]  <= wr_data_i;
            end
            // output holds between reads
            if (rd_en_i) begin
                tag_q   <= tag_mem[set_index_i];
                state_q <= state_mem[set_index_i];
                data_q  <= data_mem[set_index_i];
            end
        end

        assign way_tag_o[w]   = tag_q;
        assign way_state_o[w] = state_q;
        assign way_data_o[w]  = data_q;
    end

    a_no_write_in_sweep: assert property (@(posedge clk_i) disable iff (nreset_i)
        wr_en_i |-> init_done_o);

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int sets_p        = 16,
    parameter int block_words_p = 4,
    localparam int offset_w     = $clog2(block_words_p) + 2,
    localparam int index_w      = $clog2(sets_p),
    localparam int tag_w        = 32 - offset_w - index_w,
    localparam int block_bits   = block_words_p * 32
) (
    input  wire logic                             clk_i,
    input  wire logic                             nreset_i,
    input  wire logic                             core_valid_i,
    input  wire wb_cache_pkg::core_req_t          core_req_i,
    input  wire logic                             init_done_i,
    input  wire logic                             hit_i,
    input  wire logic                             hit_way_i,
    input  wire logic                             victim_way_i,
    input  wire wb_cache_pkg::block_state_e [1:0] way_state_i,
    input  wire logic [1:0][tag_w-1:0]            way_tag_i,
    input  wire logic [1:0][block_bits-1:0]       way_data_i,
    input  wire wb_cache_pkg::word_t              load_word_i,
    input  wire logic [block_bits-1:0]            merged_block_i,
    input  wire logic                             bus_yumi_i,
    input  wire logic                             bus_rsp_valid_i,
    input  wire logic [block_bits-1:0]            bus_rdata_i,

    output logic                                  core_ready_o,
    output logic                                  core_rsp_valid_o,
    output wb_cache_pkg::core_rsp_t               core_rsp_o,
    output logic                                  bus_valid_o,
    output wb_cache_pkg::bus_req_t                bus_req_o,
    output logic [block_bits-1:0]                 bus_wdata_o,
    output logic                                  rd_en_o,
    output logic [index_w-1:0]                    set_index_o,
    output logic                                  wr_en_o,
    output logic                                  wr_way_o,
    output logic [tag_w-1:0]                      wr_tag_o,
    output wb_cache_pkg::block_state_e            wr_state_o,
    output logic [block_bits-1:0]                 wr_data_o,
    output logic                                  lru_touch_o,
    output wb_cache_pkg::core_req_t               req_o
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_write_back,
        s_read_req,
        s_refill
    } ctrl_state_e;

    ctrl_state_e             state_r;
    ctrl_state_e             state_n;
    wb_cache_pkg::core_req_t req_r;
    logic                    accept;
    logic                    respond;
    logic                    victim_dirty;
    logic [tag_w-1:0]        bus_tag;

    assign accept       = core_valid_i && core_ready_o;
    assign core_ready_o = (state_r == s_idle) && init_done_i;
    assign req_o        = req_r;
    assign victim_dirty = way_state_i[victim_way_i] == wb_cache_pkg::state_dirty;

    always_comb begin
        state_n = state_r;
        case (state_r)
            s_idle:       state_n = accept ? s_lookup : s_idle;
            s_lookup: begin
                if (hit_i) begin
                    state_n = s_idle;
                end else if (victim_dirty) begin
                    state_n = s_write_back;
                end else begin
                    state_n = s_read_req;
                end
            end
            s_write_back: state_n = bus_yumi_i ? s_read_req : s_write_back;
            s_read_req:   state_n = bus_yumi_i ? s_refill : s_read_req;
            s_refill:     state_n = bus_rsp_valid_i ? s_idle : s_refill;
            default:      state_n = s_idle;
        endcase
    end

    // hit answers from lookup, miss from the refill beat
    assign respond = (state_r == s_lookup && hit_i) || (state_r == s_refill && bus_rsp_valid_i);

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r          <= s_idle;
            core_rsp_valid_o <= 1'b0;
        end else begin
            state_r          <= state_n;
            core_rsp_valid_o <= respond;
        end
        if (accept) begin
            req_r <= core_req_i;
        end
        if (respond) begin
            core_rsp_o.rdata <= req_r.write ? '0 : load_word_i;
        end
    end

    // arrays are read while the request is taken
    assign rd_en_o     = accept;
    assign set_index_o = accept ? core_req_i.addr[offset_w +: index_w]
                                : req_r.addr[offset_w +: index_w];

    assign bus_valid_o = (state_r == s_write_back) || (state_r == s_read_req);
    assign bus_tag     = (state_r == s_write_back) ? way_tag_i[victim_way_i]
                                                   : req_r.addr[31 -: tag_w];
    assign bus_req_o   = '{
        op:   (state_r == s_write_back) ? wb_cache_pkg::op_write_back
                                        : wb_cache_pkg::op_read_block,
        addr: {bus_tag, req_r.addr[offset_w +: index_w], {offset_w{1'b0}}}
    };

    // victim line during eviction, hit line in lookup, fill data on refill
    assign bus_wdata_o = (state_r == s_refill) ? bus_rdata_i
                                               : way_data_i[hit_i ? hit_way_i : victim_way_i];

    assign wr_en_o     = (state_r == s_lookup && hit_i && req_r.write)
                       || (state_r == s_refill && bus_rsp_valid_i);
    assign wr_way_o    = (state_r == s_lookup) ? hit_way_i : victim_way_i;
    assign wr_tag_o    = req_r.addr[31 -: tag_w];
    assign wr_state_o  = req_r.write ? wb_cache_pkg::state_dirty : wb_cache_pkg::state_clean;
    assign wr_data_o   = req_r.write ? merged_block_i : bus_rdata_i;
    assign lru_touch_o = respond;

    a_rsp_in_refill: assert property (@(posedge clk_i) disable iff (nreset_i)
        bus_rsp_valid_i |-> state_r == s_refill);

    a_lookup_one_cycle: assert property (@(posedge clk_i) disable iff (nreset_i)
        state_r == s_lookup |=> state_r != s_lookup);

    // victim chosen by way_select must still be dirty in the arrays
    a_wb_only_dirty: assert property (@(posedge clk_i) disable iff (nreset_i)
        bus_valid_o && bus_req_o.op == wb_cache_pkg::op_write_back |-> victim_dirty);

endmodule

`default_nettype wire

/* rtl/store_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module store_merge #(
    parameter int block_words_p = 4,
    localparam int offset_w     = $clog2(block_words_p) + 2,
    localparam int block_bits   = block_words_p * 32
) (
    input  wire logic [block_bits-1:0] block_i,
    input  wire wb_cache_pkg::addr_t   addr_i,
    input  wire wb_cache_pkg::be_t     be_i,
    input  wire wb_cache_pkg::word_t   wdata_i,
    output wb_cache_pkg::word_t        load_word_o,
    output logic [block_bits-1:0]      merged_block_o
);

    localparam int byte_sel_w = $clog2(wb_cache_pkg::WORD_BYTES);

    logic [offset_w-byte_sel_w-1:0] word_idx;

    assign word_idx    = addr_i[offset_w-1:byte_sel_w];
    assign load_word_o = block_i[word_idx*32 +: 32];

    // only enabled lanes of the addressed word change
    always_comb begin
        merged_block_o = block_i;
        for (int b = 0; b < wb_cache_pkg::WORD_BYTES; b++) begin
            if (be_i[b]) begin
                merged_block_o[word_idx*32 + b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/way_select.sv */
`timescale 1ns/1ps
`default_nettype none

module way_select #(
    parameter int sets_p        = 16,
    parameter int block_words_p = 4,
    localparam int offset_w     = $clog2(block_words_p) + 2,
    localparam int index_w      = $clog2(sets_p),
    localparam int tag_w        = 32 - offset_w - index_w
) (
    input  wire logic                             clk_i,
    input  wire logic                             nreset_i,
    input  wire logic [tag_w-1:0]                 req_tag_i,
    input  wire logic [index_w-1:0]               set_index_i,
    input  wire logic [1:0][tag_w-1:0]            way_tag_i,
    input  wire wb_cache_pkg::block_state_e [1:0] way_state_i,
    input  wire logic                             lru_touch_i,
    output logic                                  hit_o,
    output logic                                  hit_way_o,
    output logic                                  victim_way_o
);

    logic [1:0]        hit_vec;
    // one bit per set, holds the most recently used way
    logic [sets_p-1:0] mru_r;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = (way_state_i[w] != wb_cache_pkg::state_invalid)
                      && (way_tag_i[w] == req_tag_i);
        end
    end

    assign hit_o     = |hit_vec;
    assign hit_way_o = hit_vec[1];

    // fill an empty way before evicting
    always_comb begin
        if (way_state_i[0] == wb_cache_pkg::state_invalid) begin
            victim_way_o = 1'b0;
        end else if (way_state_i[1] == wb_cache_pkg::state_invalid) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~mru_r[set_index_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            mru_r <= '0;
        end else if (lru_touch_i) begin
            mru_r[set_index_i] <= hit_o ? hit_way_o : victim_way_o;
        end
    end

    // tags written by the refill path never repeat within a set
    a_one_way_hits: assert property (@(posedge clk_i) disable iff (nreset_i)
        lru_touch_i |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

/* rtl/wb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_cache #(
    parameter int sets_p        = 16,
    parameter int block_words_p = 4,
    localparam int offset_w     = $clog2(block_words_p) + 2,
    localparam int index_w      = $clog2(sets_p),
    localparam int tag_w        = 32 - offset_w - index_w,
    localparam int block_bits   = block_words_p * 32
) (
    input  wire logic                   clk_i,
    input  wire logic                   nreset_i,

    input  wire logic                   core_valid_i,
    output logic                        core_ready_o,
    input  wire wb_cache_pkg::core_req_t core_req_i,
    output logic                        core_rsp_valid_o,
    output wb_cache_pkg::core_rsp_t     core_rsp_o,

    output logic                        bus_valid_o,
    input  wire logic                   bus_yumi_i,
    output wb_cache_pkg::bus_req_t      bus_req_o,
    output logic [block_bits-1:0]       bus_wdata_o,
    input  wire logic                   bus_rsp_valid_i,
    input  wire logic [block_bits-1:0]  bus_rdata_i
);

    logic                              init_done;
    logic                              hit;
    logic                              hit_way;
    logic                              victim_way;
    wb_cache_pkg::block_state_e [1:0]  way_state;
    logic [1:0][tag_w-1:0]             way_tag;
    logic [1:0][block_bits-1:0]        way_data;
    wb_cache_pkg::word_t               load_word;
    logic [block_bits-1:0]             merged_block;
    logic                              rd_en;
    logic [index_w-1:0]                set_index;
    logic                              wr_en;
    logic                              wr_way;
    logic [tag_w-1:0]                  wr_tag;
    wb_cache_pkg::block_state_e        wr_state;
    logic [block_bits-1:0]             wr_data;
    logic                              lru_touch;
    wb_cache_pkg::core_req_t           req;

    cache_ctrl #(
        .sets_p        (sets_p),
        .block_words_p (block_words_p)
    ) i_ctrl (
        .clk_i, .nreset_i, .core_valid_i, .core_req_i,
        .init_done_i      (init_done),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .way_state_i      (way_state),
        .way_tag_i        (way_tag),
        .way_data_i       (way_data),
        .load_word_i      (load_word),
        .merged_block_i   (merged_block),
        .bus_yumi_i, .bus_rsp_valid_i, .bus_rdata_i,
        .core_ready_o, .core_rsp_valid_o, .core_rsp_o,
        .bus_valid_o, .bus_req_o, .bus_wdata_o,
        .rd_en_o          (rd_en),
        .set_index_o      (set_index),
        .wr_en_o          (wr_en),
        .wr_way_o         (wr_way),
        .wr_tag_o         (wr_tag),
        .wr_state_o       (wr_state),
        .wr_data_o        (wr_data),
        .lru_touch_o      (lru_touch),
        .req_o            (req)
    );

    way_select #(
        .sets_p        (sets_p),
        .block_words_p (block_words_p)
    ) i_way_select (
        .clk_i, .nreset_i,
        .req_tag_i    (req.addr[31 -: tag_w]),
        .set_index_i  (set_index),
        .way_tag_i    (way_tag),
        .way_state_i  (way_state),
        .lru_touch_i  (lru_touch),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way)
    );

    // ctrl keeps the line being worked on at the write data port
    store_merge #(
        .block_words_p (block_words_p)
    ) i_store_merge (
        .block_i        (bus_wdata_o),
        .addr_i         (req.addr),
        .be_i           (req.be),
        .wdata_i        (req.wdata),
        .load_word_o    (load_word),
        .merged_block_o (merged_block)
    );

    cache_arrays #(
        .sets_p        (sets_p),
        .block_words_p (block_words_p)
    ) i_arrays (
        .clk_i, .nreset_i,
        .rd_en_i     (rd_en),
        .set_index_i (set_index),
        .wr_en_i     (wr_en),
        .wr_way_i    (wr_way),
        .wr_tag_i    (wr_tag),
        .wr_state_i  (wr_state),
        .wr_data_i   (wr_data),
        .way_tag_o   (way_tag),
        .way_state_o (way_state),
        .way_data_o  (way_data),
        .init_done_o (init_done)
    );

endmodule

`default_nettype wire

/* rtl/wb_cache_pkg.sv */
`default_nettype none

package wb_cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;

    localparam int WORD_BYTES = 4;

    // per-line state, no coherence
    typedef enum logic [1:0] {
        state_invalid = 2'd0,
        state_clean   = 2'd1,
        state_dirty   = 2'd2
    } block_state_e;

    typedef enum logic {
        op_read_block = 1'b0,
        op_write_back = 1'b1
    } bus_op_e;

    typedef struct packed {
        logic  write;
        be_t   be;
        addr_t addr;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        word_t rdata;
    } core_rsp_t;

    // addr is always block aligned
    typedef struct packed {
        bus_op_e op;
        addr_t   addr;
    } bus_req_t;

endpackage

`default_nettype wire

/* testbench/tb_mem_model.svh */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

integer                delay_seed = 32'h05f4_435b;
logic [block_bits-1:0] mem_blocks [wb_cache_pkg::addr_t];
wb_cache_pkg::word_t   ref_words [wb_cache_pkg::addr_t];
int                    rd_count = 0;
int                    wb_count = 0;
wb_cache_pkg::addr_t   last_rd_addr;
wb_cache_pkg::addr_t   last_wb_addr;

// every word address gives its own value
function automatic wb_cache_pkg::word_t fill_word(input wb_cache_pkg::addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
endfunction

function automatic wb_cache_pkg::word_t ref_word(input wb_cache_pkg::addr_t a);
    wb_cache_pkg::addr_t wa;
    wa = {a[31:2], 2'b00};
    return ref_words.exists(wa) ? ref_words[wa] : fill_word(wa);
endfunction

function automatic logic [block_bits-1:0] ref_block(input wb_cache_pkg::addr_t a);
    logic [block_bits-1:0] blk;
    for (int i = 0; i < block_words_p; i++) begin
        blk[i*32 +: 32] = ref_word(a + 4 * i);
    end
    return blk;
endfunction

function automatic logic [block_bits-1:0] mem_block(input wb_cache_pkg::addr_t a);
    logic [block_bits-1:0] blk;
    for (int i = 0; i < block_words_p; i++) begin
        blk[i*32 +: 32] = fill_word(a + 4 * i);
    end
    return mem_blocks.exists(a) ? mem_blocks[a] : blk;
endfunction

// expected response, stores update the flat word memory lane by lane
function automatic wb_cache_pkg::word_t ref_access(input wb_cache_pkg::core_req_t r);
    wb_cache_pkg::word_t w;
    w = ref_word(r.addr);
    if (!r.write) begin
        return w;
    end
    for (int b = 0; b < wb_cache_pkg::WORD_BYTES; b++) begin
        if (r.be[b]) begin
            w[b*8 +: 8] = r.wdata[b*8 +: 8];
        end
    end
    ref_words[{r.addr[31:2], 2'b00}] = w;
    return '0;
endfunction

initial begin : bus_model
    wb_cache_pkg::bus_req_t req;
    logic [block_bits-1:0]  wdata;
    int                     wait_cycles;
    bus_yumi_i      = 1'b0;
    bus_rsp_valid_i = 1'b0;
    bus_rdata_i     = '0;
    forever begin
        @(posedge clk_i);
        if (!nreset_i && bus_valid_o) begin
            req   = bus_req_o;
            wdata = bus_wdata_o;
            if (req.addr[offset_w-1:0] != '0) begin
                fail_note($sformatf("bus address %h is not block aligned", req.addr));
            end
            wait_cycles = $unsigned($random(delay_seed)) % 4;
            repeat (wait_cycles) @(posedge clk_i);
            #0.5;
            bus_yumi_i = 1'b1;
            @(posedge clk_i);
            if (bus_valid_o !== 1'b1 || bus_req_o !== req || bus_wdata_o !== wdata) begin
                fail_note("bus request changed while waiting for yumi");
            end
            #0.5;
            bus_yumi_i = 1'b0;
            if (req.op == wb_cache_pkg::op_write_back) begin
                wb_count++;
                last_wb_addr         = req.addr;
                mem_blocks[req.addr] = wdata;
                if (wdata !== ref_block(req.addr)) begin
                    value_error("bus_wdata_o", wdata, ref_block(req.addr));
                end
            end else begin
                rd_count++;
                last_rd_addr = req.addr;
                wait_cycles  = $unsigned($random(delay_seed)) % 4;
                repeat (wait_cycles) begin
                    @(posedge clk_i);
                    #0.5;
                end
                bus_rsp_valid_i = 1'b1;
                bus_rdata_i     = mem_block(req.addr);
                @(posedge clk_i);
                #0.5;
                bus_rsp_valid_i = 1'b0;
            end
        end
    end
end

`endif

/* testbench/tb_wb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_cache;

    localparam int sets_p         = 16;
    localparam int block_words_p  = 4;
    localparam int block_bits     = block_words_p * 32;
    localparam int offset_w       = $clog2(block_words_p) + 2;
    localparam int index_w        = $clog2(sets_p);
    localparam int random_reqs    = 300;
    // directed tests issue 18 requests
    localparam int timeout_cycles = (random_reqs + 18) * 40 + 200;

    logic                    clk_i = 1'b0;
    logic                    nreset_i;
    logic                    core_valid_i;
    logic                    core_ready_o;
    wb_cache_pkg::core_req_t core_req_i;
    logic                    core_rsp_valid_o;
    wb_cache_pkg::core_rsp_t core_rsp_o;
    logic                    bus_valid_o;
    logic                    bus_yumi_i;
    wb_cache_pkg::bus_req_t  bus_req_o;
    logic [block_bits-1:0]   bus_wdata_o;
    logic                    bus_rsp_valid_i;
    logic [block_bits-1:0]   bus_rdata_i;

    int                  cycle = 0;
    int                  error_count = 0;
    int                  rsp_checked = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  test_errors_start = 0;
    int                  accept_cycle;
    int                  latency;
    integer              stim_seed = 32'h05f4_435b;
    wb_cache_pkg::word_t exp_q [$];

    `include "tb_mem_model.svh"

    wb_cache #(.sets_p(sets_p), .block_words_p(block_words_p)) i_dut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles, a request never completed", cycle);
            $display("*** FAILED ***");
            $finish;
        end
    end

    always @(posedge clk_i) begin : compare_rsp
        wb_cache_pkg::word_t expected;
        if (!nreset_i && core_rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_note("core response with no request outstanding");
            end else begin
                expected = exp_q.pop_front();
                rsp_checked++;
                if (core_rsp_o.rdata !== expected) begin
                    value_error("core_rsp_o.rdata", core_rsp_o.rdata, expected);
                end
            end
        end
    end

    task automatic value_error(input string name, input logic [block_bits-1:0] got,
                               input logic [block_bits-1:0] exp);
        $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic fail_note(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == test_errors_start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", name, error_count - test_errors_start);
        end
        test_errors_start = error_count;
    endtask

    function automatic wb_cache_pkg::addr_t make_addr(input int tag, input int set, input int word);
        return (tag << (offset_w + index_w)) | (set << offset_w) | (word << 2);
    endfunction

    // one request, from drive to response
    task automatic send_req(input wb_cache_pkg::core_req_t r);
        core_valid_i = 1'b1;
        core_req_i   = r;
        do @(posedge clk_i); while (!core_ready_o);
        accept_cycle = cycle;
        exp_q.push_back(ref_access(r));
        #0.5;
        core_valid_i = 1'b0;
        do @(posedge clk_i); while (!core_rsp_valid_o);
        latency = cycle - accept_cycle;
        #0.5;
    endtask

    task automatic load_word(input wb_cache_pkg::addr_t a);
        send_req('{write: 1'b0, be: 4'h0, addr: a, wdata: '0});
    endtask

    task automatic store_word(input wb_cache_pkg::addr_t a, input wb_cache_pkg::be_t be,
                              input wb_cache_pkg::word_t d);
        send_req('{write: 1'b1, be: be, addr: a, wdata: d});
    endtask

    initial begin : main
        int                      low_cycles;
        int                      rd_before;
        int                      wb_before;
        logic [31:0]             rnd;
        wb_cache_pkg::core_req_t r;
        wb_cache_pkg::be_t       be_list [8];
        nreset_i     = 1'b1;
        core_valid_i = 1'b0;
        core_req_i   = '0;
        be_list      = '{4'h1, 4'h6, 4'h8, 4'hf, 4'h5, 4'ha, 4'h3, 4'hc};
        repeat (2) @(posedge clk_i);
        if (core_ready_o !== 1'b0) value_error("core_ready_o", core_ready_o, 0);
        if (core_rsp_valid_o !== 1'b0) value_error("core_rsp_valid_o", core_rsp_valid_o, 0);
        if (bus_valid_o !== 1'b0) value_error("bus_valid_o", bus_valid_o, 0);
        #0.5;
        nreset_i   = 1'b0;
        low_cycles = 0;
        @(posedge clk_i);
        while (core_ready_o !== 1'b1) begin
            low_cycles++;
            @(posedge clk_i);
        end
        #0.5;
        if (low_cycles != sets_p) begin
            fail_note($sformatf("core_ready_o rose %0d cycles after reset, not %0d",
                                low_cycles, sets_p));
        end
        end_test("1 reset sweep");

        rd_before = rd_count;
        wb_before = wb_count;
        load_word(make_addr(1, 3, 2));
        if (rd_count != rd_before + 1 || wb_count != wb_before) begin
            fail_note("load miss did not issue exactly one bus read");
        end
        if (last_rd_addr !== make_addr(1, 3, 0)) begin
            value_error("bus_req_o.addr", last_rd_addr, make_addr(1, 3, 0));
        end
        end_test("2 load miss");

        load_word(make_addr(1, 3, 1));
        if (rd_count != rd_before + 1 || wb_count != wb_before) begin
            fail_note("load hit issued a bus request");
        end
        if (latency != 2) fail_note($sformatf("hit answered after %0d cycles, not 2", latency));
        end_test("3 load hit");

        for (int i = 0; i < 8; i++) begin
            store_word(make_addr(2, 5, i % block_words_p), be_list[i],
                       32'hc3a5_9e10 ^ (i * 32'h1357_2468));
        end
        for (int i = 0; i < block_words_p; i++) begin
            load_word(make_addr(2, 5, i));
        end
        end_test("4 byte enables");

        store_word(make_addr(4, 9, 0), 4'hf, 32'h1111_4444);
        store_word(make_addr(5, 9, 1), 4'h3, 32'h2222_5555);
        wb_before = wb_count;
        store_word(make_addr(6, 9, 2), 4'hc, 32'h3333_6666);
        if (wb_count != wb_before + 1) fail_note("third tag in set 9 did not write back once");
        if (last_wb_addr !== make_addr(4, 9, 0)) begin
            value_error("bus_req_o.addr", last_wb_addr, make_addr(4, 9, 0));
        end
        load_word(make_addr(4, 9, 0));
        end_test("5 dirty eviction");

        for (int i = 0; i < random_reqs; i++) begin
            rnd     = $random(stim_seed);
            r.write = rnd[0];
            r.be    = rnd[7:4];
            r.addr  = make_addr(rnd[9:8], rnd[13:12] % 3, rnd[17:16] % block_words_p);
            r.wdata = $random(stim_seed);
            send_req(r);
        end
        if (exp_q.size() != 0) fail_note("requests left without a response");
        end_test("6 random mix");

        $display("tests run %0d, tests failed %0d, responses checked %0d, errors %0d",
                 tests_run, tests_failed, rsp_checked, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wb_cache.f */
+incdir+testbench
rtl/wb_cache_pkg.sv
rtl/store_merge.sv
rtl/cache_arrays.sv
rtl/way_select.sv
rtl/cache_ctrl.sv
rtl/wb_cache.sv
testbench/tb_wb_cache.sv
